// ==== logic/axil_regs.sv ====
module axil_regs #(
    parameter int HIDDEN = 4,
    parameter int INPUT  = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lstm_pkg::axil_req_t  axil_req,
    output lstm_pkg::axil_rsp_t  axil_rsp,
    output logic                 start,
    output logic                 clear,
    input  logic                 done,
    input  logic [1:0]           w_tile,
    input  logic [2:0]           w_col,
    output lstm_pkg::wcol_t      w_data,
    output lstm_pkg::q88_t       x_data,
    input  lstm_pkg::state_vec_t h,
    input  lstm_pkg::state_vec_t c
);
    import lstm_pkg::*;

    localparam int IDX_W = AXIL_ADDR_W - 2;

    // Bank n holds rows with row mod 4 == n, entry {row tile, col}
    q88_t bank_mem [TILE][32];
    q88_t x_reg [INPUT];

    logic                   busy;
    logic                   done_flag;
    logic                   bvalid_q;
    axil_resp_t             bresp_q;
    logic                   rvalid_q;
    logic [AXIL_DATA_W-1:0] rdata_q;
    logic [AXIL_DATA_W-1:0] rd_word;

    logic             wr_take;
    logic             rd_take;
    logic [IDX_W-1:0] wx_idx;
    logic [IDX_W-1:0] ww_idx;
    logic [IDX_W-1:0] rx_idx;
    logic [IDX_W-1:0] rw_idx;
    logic [IDX_W-1:0] rh_idx;
    logic [IDX_W-1:0] rc_idx;
    logic             wr_ctrl;
    logic             wr_x;
    logic             wr_w;
    logic             wr_err;
    logic             rd_w;
    logic             start_req;

    // Word offset into a region, wraps large when below the base
    function automatic logic [IDX_W-1:0] word_idx(input logic [AXIL_ADDR_W-1:0] a,
                                                  input logic [AXIL_ADDR_W-1:0] base);
        logic [AXIL_ADDR_W-1:0] off;
        off = a - base;
        return off[AXIL_ADDR_W-1:2];
    endfunction

    function automatic logic [AXIL_DATA_W-1:0] sext(input q88_t v);
        return {{(AXIL_DATA_W - 16){v[15]}}, v};
    endfunction

    // AW and W are taken together, nothing new while a response waits
    assign wr_take = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_take = axil_req.arvalid && !rvalid_q;

    assign wx_idx  = word_idx(axil_req.awaddr, ADDR_X_BASE);
    assign ww_idx  = word_idx(axil_req.awaddr, ADDR_W_BASE);
    assign wr_ctrl = word_idx(axil_req.awaddr, ADDR_CTRL) == '0;
    assign wr_x    = wx_idx < INPUT;
    assign wr_w    = ww_idx < W_WORDS && ww_idx[2:0] < INPUT && ww_idx[6:3] < 4 * HIDDEN;
    assign wr_err  = busy && (wr_ctrl || wr_x || wr_w);

    assign start_req = wr_take && wr_ctrl && !busy && axil_req.wdata[0];

    assign rx_idx = word_idx(axil_req.araddr, ADDR_X_BASE);
    assign rw_idx = word_idx(axil_req.araddr, ADDR_W_BASE);
    assign rh_idx = word_idx(axil_req.araddr, ADDR_H_BASE);
    assign rc_idx = word_idx(axil_req.araddr, ADDR_C_BASE);
    assign rd_w   = rw_idx < W_WORDS && rw_idx[2:0] < INPUT && rw_idx[6:3] < 4 * HIDDEN;

    always_comb begin
        rd_word = '0;
        if (word_idx(axil_req.araddr, ADDR_STATUS) == '0)
            rd_word = {{(AXIL_DATA_W - 2){1'b0}}, done_flag, busy};
        else if (rx_idx < INPUT)
            rd_word = sext(x_reg[rx_idx[2:0]]);
        else if (rh_idx < HIDDEN)
            rd_word = sext(h.v[rh_idx[1:0]]);
        else if (rc_idx < HIDDEN)
            rd_word = sext(c.v[rc_idx[1:0]]);
        else if (rd_w)
            rd_word = sext(bank_mem[rw_idx[4:3]][{rw_idx[6:5], rw_idx[2:0]}]);
    end

    always_comb begin
        axil_rsp         = '0;
        axil_rsp.awready = wr_take;
        axil_rsp.wready  = wr_take;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = !rvalid_q;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = RESP_OKAY;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid_q  <= 1'b0;
            bresp_q   <= RESP_OKAY;
            rvalid_q  <= 1'b0;
            start     <= 1'b0;
            clear     <= 1'b0;
            busy      <= 1'b0;
            done_flag <= 1'b0;
        end else begin
            start <= start_req;
            clear <= wr_take && wr_ctrl && !busy && axil_req.wdata[1];
            if (wr_take) begin
                bvalid_q <= 1'b1;
                bresp_q  <= wr_err ? RESP_SLVERR : RESP_OKAY;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_take)
                rvalid_q <= 1'b1;
            else if (axil_req.rready)
                rvalid_q <= 1'b0;
            // Done stays visible until the next start
            if (start_req) begin
                busy      <= 1'b1;
                done_flag <= 1'b0;
            end else if (done) begin
                busy      <= 1'b0;
                done_flag <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take)
            rdata_q <= rd_word;
        if (wr_take && !busy && wr_x)
            x_reg[wx_idx[2:0]] <= axil_req.wdata[15:0];
        if (wr_take && !busy && wr_w)
            bank_mem[ww_idx[4:3]][{ww_idx[6:5], ww_idx[2:0]}] <= axil_req.wdata[15:0];
    end

    // Engine fetch, whole tile column plus its x element
    always_ff @(posedge clk) begin
        for (int b = 0; b < TILE; b++)
            w_data.v[b] <= bank_mem[b][{w_tile, w_col}];
        x_data <= x_reg[w_col];
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_q && !axil_req.bready |=> bvalid_q);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_q && !axil_req.rready |=> rvalid_q && $stable(rdata_q));

endmodule

// ==== logic/cell_update.sv ====
module cell_update (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clear,
    input  logic                 gate_valid,
    input  lstm_pkg::gate_vec_t  gate_in,
    output lstm_pkg::state_vec_t h,
    output lstm_pkg::state_vec_t c,
    output logic                 done
);
    import lstm_pkg::*;

    cell_state_t state;
    gate_t       next_gate;

    // Activated gates, one entry per lane
    q88_t f_q [TILE];
    q88_t i_q [TILE];
    q88_t g_q [TILE];
    q88_t o_q [TILE];
    q88_t act [TILE];
    q88_t c_new [TILE];
    q88_t h_new [TILE];

    // p/4 + 0.5, clamped to [0, 1.0]
    function automatic q88_t hard_sigmoid(input q88_t p);
        q88_t t;
        t = (p >>> 2) + 16'sd128;
        if (t < 16'sd0)
            return 16'sd0;
        if (t > 16'sd256)
            return 16'sd256;
        return t;
    endfunction

    function automatic q88_t hard_tanh(input q88_t p);
        if (p > 16'sd256)
            return 16'sd256;
        if (p < -16'sd256)
            return -16'sd256;
        return p;
    endfunction

    for (genvar l = 0; l < TILE; l++) begin : g_lane
        acc_t fc;
        acc_t ig;
        acc_t oh;
        q88_t c_l;
        q88_t tc;

        assign act[l] = (gate_in.gate == GATE_CAND) ? hard_tanh(gate_in.pre[l]) :
                                                      hard_sigmoid(gate_in.pre[l]);
        assign c_l      = c.v[l];
        assign fc       = f_q[l] * c_l;
        assign ig       = i_q[l] * g_q[l];
        assign c_new[l] = sat_q88((fc + ig) >>> FRAC_BITS);
        assign tc       = hard_tanh(c_new[l]);
        assign oh       = o_q[l] * tc;
        assign h_new[l] = sat_q88(oh >>> FRAC_BITS);
    end

    always_ff @(posedge clk) begin
        if (gate_valid) begin
            for (int l = 0; l < TILE; l++) begin
                case (gate_in.gate)
                    GATE_FORGET: f_q[l] <= act[l];
                    GATE_INPUT:  i_q[l] <= act[l];
                    GATE_CAND:   g_q[l] <= act[l];
                    default:     o_q[l] <= act[l];
                endcase
            end
        end
    end

    // Output gate closes the collection, the update follows a cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CELL_COLLECT;
            next_gate <= GATE_FORGET;
            done      <= 1'b0;
            c         <= '0;
            h         <= '0;
        end else begin
            done <= 1'b0;
            if (gate_valid)
                next_gate <= gate_t'(next_gate + 2'd1);
            case (state)
                CELL_COLLECT: begin
                    if (gate_valid && gate_in.gate == GATE_OUTPUT)
                        state <= CELL_UPDATE;
                end
                default: begin
                    state <= CELL_COLLECT;
                    done  <= 1'b1;
                    for (int l = 0; l < TILE; l++) begin
                        c.v[l] <= c_new[l];
                        h.v[l] <= h_new[l];
                    end
                end
            endcase
            if (clear) begin
                c <= '0;
                h <= '0;
            end
        end
    end

    // Row tiles come out of the engine in gate order
    a_gate_order: assert property (@(posedge clk) disable iff (!rst_n)
        gate_valid |-> gate_in.gate == next_gate);

endmodule

// ==== logic/lstm_cell_top.sv ====
module lstm_cell_top #(
    parameter int HIDDEN = 4,
    parameter int INPUT  = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  lstm_pkg::axil_req_t axil_req,
    output lstm_pkg::axil_rsp_t axil_rsp
);
    import lstm_pkg::*;

    // Control between register block, engine and cell
    logic start;
    logic clear;
    logic done;

    // Weight column fetch
    logic [1:0] w_tile;
    logic [2:0] w_col;
    wcol_t      w_data;
    q88_t       x_data;

    // Preactivations, one gate per row tile
    logic      gate_valid;
    gate_vec_t gate_vec;

    // Recurrent state seen by the host
    state_vec_t h;
    state_vec_t c;

    axil_regs #(
        .HIDDEN(HIDDEN),
        .INPUT (INPUT)
    ) i_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .start   (start),
        .clear   (clear),
        .done    (done),
        .w_tile  (w_tile),
        .w_col   (w_col),
        .w_data  (w_data),
        .x_data  (x_data),
        .h       (h),
        .c       (c)
    );

    tile_mvm #(
        .INPUT(INPUT)
    ) i_mvm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .w_tile    (w_tile),
        .w_col     (w_col),
        .w_data    (w_data),
        .x_data    (x_data),
        .gate_valid(gate_valid),
        .gate_out  (gate_vec)
    );

    cell_update i_cell (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .gate_valid(gate_valid),
        .gate_in   (gate_vec),
        .h         (h),
        .c         (c),
        .done      (done)
    );

endmodule

// ==== logic/lstm_pkg.sv ====
package lstm_pkg;

    // Datapath geometry
    localparam int TILE      = 4;
    localparam int FRAC_BITS = 8;

    // AXI4-Lite widths
    localparam int AXIL_ADDR_W = 12;
    localparam int AXIL_DATA_W = 32;

    // Signed Q8.8 operand and the wide MAC accumulator
    typedef logic signed [15:0] q88_t;
    typedef logic signed [31:0] acc_t;

    // Register map, byte addresses
    localparam logic [AXIL_ADDR_W-1:0] ADDR_CTRL   = 12'h000;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS = 12'h004;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_X_BASE = 12'h040;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_H_BASE = 12'h080;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_C_BASE = 12'h0A0;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_W_BASE = 12'h200;
    localparam int                     W_WORDS     = 128;

    // Row tile index doubles as the gate tag
    typedef enum logic [1:0] {GATE_FORGET, GATE_INPUT, GATE_CAND, GATE_OUTPUT} gate_t;

    typedef enum logic [1:0] {RESP_OKAY = 2'b00, RESP_SLVERR = 2'b10} axil_resp_t;

    typedef enum logic [1:0] {MVM_IDLE, MVM_RUN, MVM_DRAIN} mvm_state_t;

    typedef enum logic {CELL_COLLECT, CELL_UPDATE} cell_state_t;

    typedef struct packed {
        logic                   awvalid;
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   wvalid;
        logic [AXIL_DATA_W-1:0] wdata;
        logic                   bready;
        logic                   arvalid;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        axil_resp_t             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        axil_resp_t             rresp;
    } axil_rsp_t;

    // One tile column, lane n holds row tile*4 + n
    typedef struct packed {
        q88_t [TILE-1:0] v;
    } wcol_t;

    typedef struct packed {
        gate_t           gate;
        q88_t [TILE-1:0] pre;
    } gate_vec_t;

    typedef struct packed {
        q88_t [TILE-1:0] v;
    } state_vec_t;

    // Clamp a wide value into the Q8.8 range
    function automatic q88_t sat_q88(input acc_t v);
        if (v > 32'sd32767)
            return 16'sh7FFF;
        if (v < -32'sd32768)
            return 16'sh8000;
        return v[15:0];
    endfunction

endpackage

// ==== logic/tile_mvm.sv ====
module tile_mvm #(
    parameter int INPUT = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    output logic [1:0]          w_tile,
    output logic [2:0]          w_col,
    input  lstm_pkg::wcol_t     w_data,
    input  lstm_pkg::q88_t      x_data,
    output logic                gate_valid,
    output lstm_pkg::gate_vec_t gate_out
);
    import lstm_pkg::*;

    mvm_state_t state;
    logic [1:0] tile_q;
    logic [2:0] col_q;
    logic       issue;

    // Tags that travel with the fetched column
    logic  rd_valid;
    logic  rd_first;
    logic  rd_last;
    gate_t rd_gate;

    q88_t pre_next [TILE];

    assign issue  = state == MVM_RUN;
    assign w_tile = tile_q;
    assign w_col  = col_q;

    // Walk row tiles 0..3, columns 0..INPUT-1, one read per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= MVM_IDLE;
            tile_q <= '0;
            col_q  <= '0;
        end else begin
            case (state)
                MVM_IDLE: begin
                    if (start) begin
                        state  <= MVM_RUN;
                        tile_q <= '0;
                        col_q  <= '0;
                    end
                end
                MVM_RUN: begin
                    if (col_q == 3'(INPUT - 1)) begin
                        col_q <= '0;
                        if (tile_q == 2'(TILE - 1))
                            state <= MVM_DRAIN;
                        else
                            tile_q <= tile_q + 2'd1;
                    end else begin
                        col_q <= col_q + 3'd1;
                    end
                end
                MVM_DRAIN: begin
                    // Last column of the output gate is in the MAC now
                    if (rd_valid && rd_last)
                        state <= MVM_IDLE;
                end
                default: state <= MVM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            rd_first <= 1'b0;
            rd_last  <= 1'b0;
            rd_gate  <= GATE_FORGET;
        end else begin
            rd_valid <= issue;
            rd_first <= col_q == '0;
            rd_last  <= col_q == 3'(INPUT - 1);
            rd_gate  <= gate_t'(tile_q);
        end
    end

    for (genvar l = 0; l < TILE; l++) begin : g_lane
        q88_t              w_l;
        acc_t              prod;
        acc_t              base;
        acc_t              acc_q;
        acc_t              acc_sat;
        logic signed [32:0] sum_wide;

        assign w_l  = w_data.v[l];
        assign prod = w_l * x_data;
        // Column tiles of one row add into the same accumulator
        assign base     = rd_first ? '0 : acc_q;
        assign sum_wide = 33'(base) + 33'(prod);
        assign acc_sat  = (sum_wide[32] != sum_wide[31]) ?
                          (sum_wide[32] ? 32'sh8000_0000 : 32'sh7FFF_FFFF) :
                          sum_wide[31:0];
        assign pre_next[l] = sat_q88(acc_sat >>> FRAC_BITS);

        always_ff @(posedge clk) begin
            if (rd_valid)
                acc_q <= acc_sat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            gate_valid <= 1'b0;
        else
            gate_valid <= rd_valid && rd_last;
    end

    always_ff @(posedge clk) begin
        if (rd_valid && rd_last) begin
            gate_out.gate <= rd_gate;
            for (int l = 0; l < TILE; l++)
                gate_out.pre[l] <= pre_next[l];
        end
    end

    // Register block keeps start off while a step runs
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> state == MVM_IDLE);

endmodule

// ==== lstm_cell_top.f ====
logic/lstm_pkg.sv
logic/axil_regs.sv
logic/tile_mvm.sv
logic/cell_update.sv
logic/lstm_cell_top.sv
verif/lstm_cell_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the LSTM cell testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f lstm_cell_top.f --top-module lstm_cell_tb -o sim_lstm_cell

./obj_dir/sim_lstm_cell | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== verif/lstm_cell_tb.sv ====
module lstm_cell_tb;
    import lstm_pkg::*;

    localparam int    HIDDEN          = 4;
    localparam int    INPUT           = 8;
    localparam int    CYCLES_PER_LINE = 200;
    localparam int    RESET_CYCLES    = 10;
    localparam int    STALL_MAX       = 3;
    localparam string TRACE_FILE      = "verif/lstm_cell_trace.txt";

    logic      clk;
    logic      rst_n;
    axil_req_t req;
    axil_rsp_t rsp;

    string lines[$];
    bit    trace_loaded = 1'b0;
    int    seed         = 58429;
    string test_name    = "";
    int    test_errors  = 0;
    int    total_errors = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    checks       = 0;

    lstm_cell_top #(
        .HIDDEN(HIDDEN),
        .INPUT (INPUT)
    ) i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .axil_req(req),
        .axil_rsp(rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic void count_error();
        test_errors++;
        total_errors++;
    endfunction

    // Strip line ends and trailing blanks
    function automatic string trim_line(input string s);
        string t;
        t = s;
        while (t.len() > 0 && (t.getc(t.len() - 1) == 8'd10 || t.getc(t.len() - 1) == 8'd13 ||
               t.getc(t.len() - 1) == 8'd32))
            t = t.substr(0, t.len() - 2);
        return t;
    endfunction

    // Only command lines are kept and lines starting with # are skipped
    function automatic bit load_trace();
        int    fd;
        string raw;
        string line;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
            return 1'b0;
        while (!$feof(fd)) begin
            raw = "";
            if ($fgets(raw, fd) > 0) begin
                line = trim_line(raw);
                if (line.len() > 0 && line.getc(0) != "#")
                    lines.push_back(line);
            end
        end
        $fclose(fd);
        return 1'b1;
    endfunction

    task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("** Error %0s: expected 0x%08h, got 0x%08h", name, exp, act);
            count_error();
        end
    endtask

    task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
        checks++;
        if (act !== exp) begin
            $display("** Error %0s: expected 0x%0h, got 0x%0h", name, exp, act);
            count_error();
        end
    endtask

    // AW and W together and B after a random stall
    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data,
                             output axil_resp_t resp);
        int stall;
        stall = $unsigned($random(seed)) % (STALL_MAX + 1);
        @(posedge clk);
        req.awvalid <= 1'b1;
        req.awaddr  <= addr;
        req.wvalid  <= 1'b1;
        req.wdata   <= data;
        @(negedge clk);
        while (!rsp.awready)
            @(negedge clk);
        if (!rsp.wready) begin
            $display("write data for 0x%03h was not accepted together with its address", addr);
            count_error();
        end
        @(posedge clk);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        repeat (stall) @(posedge clk);
        req.bready <= 1'b1;
        @(negedge clk);
        while (!rsp.bvalid)
            @(negedge clk);
        resp = rsp.bresp;
        @(posedge clk);
        req.bready <= 1'b0;
        @(negedge clk);
        if (rsp.bvalid) begin
            $display("write response for 0x%03h was delivered more than once", addr);
            count_error();
        end
    endtask

    task automatic read_reg(input logic [11:0] addr, output logic [31:0] data,
                            output axil_resp_t resp);
        int stall;
        stall = $unsigned($random(seed)) % (STALL_MAX + 1);
        @(posedge clk);
        req.arvalid <= 1'b1;
        req.araddr  <= addr;
        @(negedge clk);
        while (!rsp.arready)
            @(negedge clk);
        @(posedge clk);
        req.arvalid <= 1'b0;
        repeat (stall) @(posedge clk);
        req.rready <= 1'b1;
        @(negedge clk);
        while (!rsp.rvalid)
            @(negedge clk);
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge clk);
        req.rready <= 1'b0;
        @(negedge clk);
        if (rsp.rvalid) begin
            $display("read response for 0x%03h was delivered more than once", addr);
            count_error();
        end
    endtask

    // Optional start and a STATUS poll until the sticky done bit shows
    task automatic run_step(input bit do_start);
        axil_resp_t  resp;
        logic [31:0] status;
        if (do_start) begin
            write_reg(ADDR_CTRL, 32'h1, resp);
            check_resp("bresp[ctrl start]", RESP_OKAY, resp);
        end
        status = '0;
        while (!status[1]) begin
            read_reg(ADDR_STATUS, status, resp);
            check_resp("rresp[status]", RESP_OKAY, resp);
        end
        check_data("status after step", 32'h2, status);
    endtask

    task automatic close_test();
        if (test_name != "") begin
            tests_run++;
            if (test_errors == 0) begin
                $display("test %0s: ok", test_name);
            end else begin
                tests_failed++;
                $display("test %0s: failed with %0d errors", test_name, test_errors);
            end
        end
        test_errors = 0;
    endtask

    task automatic run_line(input string line);
        byte         kind;
        int          n;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] rdata;
        axil_resp_t  resp;
        kind = line.getc(0);
        f1   = '0;
        f2   = '0;
        f3   = '0;
        case (kind)
            "T": begin
                close_test();
                test_name = line.substr(2, line.len() - 1);
            end
            "W": begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", f1, f2, f3);
                if (n != 3) begin
                    $display("trace line has fields missing: %0s", line);
                    count_error();
                end else begin
                    write_reg(f1[11:0], f2, resp);
                    check_resp($sformatf("bresp[0x%03h]", f1[11:0]),
                               axil_resp_t'(f3[1:0]), resp);
                end
            end
            "R": begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", f1, f2, f3);
                if (n != 3) begin
                    $display("trace line has fields missing: %0s", line);
                    count_error();
                end else begin
                    read_reg(f1[11:0], rdata, resp);
                    check_data($sformatf("rdata[0x%03h]", f1[11:0]), f2, rdata);
                    check_resp($sformatf("rresp[0x%03h]", f1[11:0]),
                               axil_resp_t'(f3[1:0]), resp);
                end
            end
            "S": begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h", f1);
                if (n != 1) begin
                    $display("trace line has fields missing: %0s", line);
                    count_error();
                end else begin
                    run_step(f1[0]);
                end
            end
            default: begin
                $display("trace line not understood: %0s", line);
                count_error();
            end
        endcase
    endtask

    // Ends the run when the trace takes far longer than its length allows
    initial begin : watchdog
        wait (trace_loaded);
        repeat (lines.size() * CYCLES_PER_LINE + RESET_CYCLES) @(posedge clk);
        $display("watchdog expired, the trace did not complete in time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : main
        req   <= '0;
        rst_n <= 1'b0;
        if (!load_trace()) begin
            $display("cannot open trace file %0s", TRACE_FILE);
            $display("STATUS: FAIL");
            $finish;
        end else begin
            trace_loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            rst_n <= 1'b1;
            repeat (2) @(posedge clk);
            foreach (lines[i])
                run_line(lines[i]);
            close_test();
            $display("tests %0d, failed %0d, checks %0d, errors %0d",
                     tests_run, tests_failed, checks, total_errors);
            if (total_errors == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== verif/lstm_cell_trace.txt ====
# W addr data resp | R addr expected_data resp | S 1 start and poll, S 0 poll only | T name
# Fields in hex, resp 0 = OKAY, 2 = SLVERR; weight row r col k at 200 + r*20 + k*4
T reg_access
W 040 00000100 0
W 044 00000000 0
W 048 00000000 0
W 04C 00000000 0
W 050 00000000 0
W 054 00000000 0
W 058 00000000 0
W 05C 00000000 0
W 200 00000000 0
W 220 00000100 0
W 240 0000FF00 0
W 260 00000200 0
W 280 00000200 0
W 2A0 00000000 0
W 2C0 00000100 0
W 2E0 0000FF80 0
W 300 00000080 0
W 320 0000FF00 0
W 340 00000300 0
W 360 00000040 0
W 380 00000200 0
W 3A0 00000000 0
W 3C0 00000100 0
W 3E0 00000080 0
R 040 00000100 0
R 2E0 FFFFFF80 0
R 320 FFFFFF00 0
R 010 00000000 0
R FFC 00000000 0
T single_step
S 1
R 0A0 00000080 0
R 0A4 FFFFFF80 0
R 0A8 000000C0 0
R 0AC 00000018 0
R 080 00000080 0
R 084 FFFFFFC0 0
R 088 00000090 0
R 08C 0000000F 0
T carry_over
S 1
R 0A0 000000C0 0
R 0A4 FFFFFF20 0
R 0A8 000000F0 0
R 0AC 00000030 0
R 080 000000C0 0
R 084 FFFFFF90 0
R 088 000000B4 0
R 08C 0000001E 0
W 000 00000002 0
R 0A4 00000000 0
R 088 00000000 0
T saturation
W 040 00007F00 0
S 1
S 1
R 0A0 00000180 0
R 0A4 FFFFFF00 0
R 0A8 00000100 0
R 0AC 00000000 0
R 080 00000100 0
R 084 FFFFFF80 0
R 088 00000100 0
R 08C 00000000 0
T busy_protect
W 000 00000002 0
W 040 00000100 0
W 000 00000001 0
W 200 00007FFF 2
W 000 00000001 2
S 0
R 200 00000000 0
R 0A0 00000080 0
R 0A4 FFFFFF80 0
R 080 00000080 0
R 08C 0000000F 0
T backpressure
W 3FC 00008001 0
R 3FC FFFF8001 0
W 080 00001234 0
R 080 00000080 0
W 05C 00007FFF 0
R 05C 00007FFF 0
R 004 00000002 0
R 0A4 FFFFFF80 0
